/* include/perf_monitor_cfg.svh */
`ifndef PERF_MONITOR_CFG_SVH
`define PERF_MONITOR_CFG_SVH

// records held between the sampler and the counter bank
`define PERF_FIFO_DEPTH 4

// largest count a single delta field can hold
`define PERF_DELTA_MAX 15

// comm word bit that turns counting on
`define PERF_ENABLE_BIT 24

// value returned at readback address 30
`define PERF_CACHE_ID 32'h0000_00c1

`endif

/* source/cache_event_pkg.sv */
`default_nettype none

package cache_event_pkg;

	localparam int NUM_EVENTS = 9;
	localparam int DELTA_W = 4;

	// order sets both the strobe bit and the record field position
	typedef enum logic [3:0] {
		ev_hit,
		ev_miss,
		ev_writeback,
		ev_expired,
		ev_expired_multi,
		ev_defaulted,
		ev_rand_evict,
		ev_zero_lease,		// derived from swap falling edge
		ev_default_miss		// derived from miss and defaulted together
	} event_idx_e;

	typedef logic [NUM_EVENTS-1:0] event_vec_t;	// one strobe per event

	typedef logic [DELTA_W-1:0] delta_t;	// events since last record

	// field i sits at bits 4i+3 down to 4i
	typedef logic [NUM_EVENTS*DELTA_W-1:0] delta_record_t;

endpackage

`default_nettype wire

/* source/perf_comm_pkg.sv */
`default_nettype none

package perf_comm_pkg;

	typedef logic [63:0] counter_t;	// event or wall-time count

	typedef logic [31:0] comm_word_t;	// config in, readback out

	typedef logic [4:0] rb_addr_t;	// taken from comm bits 4..0

	// readback map
	localparam rb_addr_t RB_EVENT_LAST = 5'd17;	// 0..17 are event counter halves
	localparam rb_addr_t RB_WALL_LO = 5'd18;
	localparam rb_addr_t RB_WALL_HI = 5'd19;
	localparam rb_addr_t RB_CACHE_ID = 5'd30;

	// four-phase master side
	typedef enum logic [1:0] {
		hs_idle,		// nothing in flight
		hs_req_high,		// record presented, waiting for ack
		hs_wait_ack_low		// req dropped, waiting for ack to return to zero
	} hs_state_e;

endpackage

`default_nettype wire

/* source/event_delta_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "perf_monitor_cfg.svh"

module event_delta_sampler (
	input  wire                            clock_i,
	input  wire                            resetn_i,
	input  wire perf_comm_pkg::comm_word_t  comm_i,
	input  wire cache_event_pkg::event_vec_t events_i,
	input  wire                            swap_i,
	input  wire                            ack_i,
	output logic                           req_o,
	output cache_event_pkg::delta_record_t  record_o,
	output logic                           stall_o
);

	localparam int N = cache_event_pkg::NUM_EVENTS;
	localparam int W = cache_event_pkg::DELTA_W;
	localparam cache_event_pkg::delta_t DELTA_MAX = cache_event_pkg::delta_t'(`PERF_DELTA_MAX);
	localparam cache_event_pkg::delta_t STALL_LEVEL = DELTA_MAX - 1'b1;

	perf_comm_pkg::hs_state_e state_q;
	cache_event_pkg::delta_t deltas_q [N];
	cache_event_pkg::delta_record_t record_q;
	cache_event_pkg::event_vec_t cond;
	cache_event_pkg::event_vec_t inc;
	logic enable;
	logic swap_q;
	logic stall_q;
	logic any_pending;
	logic near_full;
	logic latch;

	assign enable = comm_i[`PERF_ENABLE_BIT];

	always_comb begin
		cond = events_i;
		cond[cache_event_pkg::ev_zero_lease] = swap_q & ~swap_i;	// swap just fell
		cond[cache_event_pkg::ev_default_miss] = events_i[cache_event_pkg::ev_miss] &
			events_i[cache_event_pkg::ev_defaulted];
		inc = (enable && !stall_q) ? cond : '0;	// held events are not counted
	end

	always_comb begin
		any_pending = 1'b0;
		near_full = 1'b0;
		for (int i = 0; i < N; i++) begin
			if (deltas_q[i] != '0) begin
				any_pending = 1'b1;
			end
			if (deltas_q[i] >= STALL_LEVEL) begin
				near_full = 1'b1;
			end
		end
	end

	// snapshot the deltas whenever the link is free
	assign latch = any_pending && (state_q == perf_comm_pkg::hs_idle);

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			swap_q <= 1'b0;
		end else if (enable) begin
			swap_q <= swap_i;	// previous enabled cycle
		end
	end

	always_ff @(posedge clock_i) begin
		for (int i = 0; i < N; i++) begin
			if (!resetn_i) begin
				deltas_q[i] <= '0;
			end else if (latch) begin
				deltas_q[i] <= cache_event_pkg::delta_t'(inc[i]);	// restart with this cycle
			end else if (inc[i] && deltas_q[i] != DELTA_MAX) begin
				deltas_q[i] <= deltas_q[i] + 1'b1;
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (latch) begin
			for (int i = 0; i < N; i++) begin
				record_q[i*W +: W] <= deltas_q[i];
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= perf_comm_pkg::hs_idle;
			stall_q <= 1'b0;
		end else begin
			case (state_q)
				perf_comm_pkg::hs_idle: begin
					if (latch) begin
						state_q <= perf_comm_pkg::hs_req_high;
					end
				end
				perf_comm_pkg::hs_req_high: begin
					if (ack_i) begin
						state_q <= perf_comm_pkg::hs_wait_ack_low;
					end
				end
				perf_comm_pkg::hs_wait_ack_low: begin
					if (!ack_i) begin
						state_q <= perf_comm_pkg::hs_idle;
					end
				end
				default: state_q <= perf_comm_pkg::hs_idle;
			endcase
			if (latch) begin
				stall_q <= 1'b0;	// deltas start over
			end else if (near_full) begin
				stall_q <= 1'b1;
			end
		end
	end

	assign req_o = (state_q == perf_comm_pkg::hs_req_high);
	assign record_o = record_q;
	assign stall_o = stall_q;

endmodule

`default_nettype wire

/* source/delta_record_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "perf_monitor_cfg.svh"

module delta_record_fifo #(
	parameter int DEPTH = `PERF_FIFO_DEPTH
) (
	input  wire                               clock_i,
	input  wire                               resetn_i,
	input  wire                               req_i,
	input  wire cache_event_pkg::delta_record_t record_i,
	input  wire                               ack_i,
	output logic                              ack_o,
	output logic                              req_o,
	output cache_event_pkg::delta_record_t     record_o
);

	localparam int AW = $clog2(DEPTH);
	localparam logic [AW:0] FULL_COUNT = (AW+1)'(DEPTH);

	cache_event_pkg::delta_record_t mem_q [DEPTH];
	perf_comm_pkg::hs_state_e state_q;
	logic [AW-1:0] wr_ptr_q;
	logic [AW-1:0] rd_ptr_q;
	logic [AW:0] count_q;
	logic in_ack_q;
	logic full;
	logic empty;
	logic push;
	logic pop;

	assign full = (count_q == FULL_COUNT);
	assign empty = (count_q == '0);
	assign push = req_i && !in_ack_q && !full;	// full buffer holds off ack
	assign pop = (state_q == perf_comm_pkg::hs_req_high) && ack_i;

	// slave side toward the sampler
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			in_ack_q <= 1'b0;
		end else if (push) begin
			in_ack_q <= 1'b1;
		end else if (!req_i) begin
			in_ack_q <= 1'b0;	// return to zero
		end
	end

	always_ff @(posedge clock_i) begin
		if (push) begin
			mem_q[wr_ptr_q] <= record_i;
		end
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;	// wraps, depth is a power of two
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push, pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// master side toward the counter bank
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= perf_comm_pkg::hs_idle;
		end else begin
			case (state_q)
				perf_comm_pkg::hs_idle: begin
					if (!empty) begin
						state_q <= perf_comm_pkg::hs_req_high;
					end
				end
				perf_comm_pkg::hs_req_high: begin
					if (ack_i) begin
						state_q <= perf_comm_pkg::hs_wait_ack_low;	// head popped here
					end
				end
				perf_comm_pkg::hs_wait_ack_low: begin
					if (!ack_i) begin
						state_q <= perf_comm_pkg::hs_idle;
					end
				end
				default: state_q <= perf_comm_pkg::hs_idle;
			endcase
		end
	end

	assign ack_o = in_ack_q;
	assign req_o = (state_q == perf_comm_pkg::hs_req_high);
	assign record_o = mem_q[rd_ptr_q];	// head stays put until popped

endmodule

`default_nettype wire

/* source/perf_counter_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "perf_monitor_cfg.svh"

module perf_counter_bank (
	input  wire                               clock_i,
	input  wire                               resetn_i,
	input  wire perf_comm_pkg::comm_word_t     comm_i,
	input  wire                               req_i,
	input  wire cache_event_pkg::delta_record_t record_i,
	output logic                              ack_o,
	output perf_comm_pkg::comm_word_t          comm_o
);

	localparam int N = cache_event_pkg::NUM_EVENTS;
	localparam int W = cache_event_pkg::DELTA_W;

	perf_comm_pkg::counter_t count_q [N];
	perf_comm_pkg::counter_t wall_q;
	perf_comm_pkg::comm_word_t rb_q;
	perf_comm_pkg::rb_addr_t rb_addr;
	logic enable;
	logic ack_q;
	logic accept;

	assign enable = comm_i[`PERF_ENABLE_BIT];
	assign rb_addr = comm_i[4:0];
	assign accept = req_i && !ack_q;	// new record, first cycle of req

	// ack follows req one cycle later and never stalls the FIFO
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req_i;
		end
	end

	always_ff @(posedge clock_i) begin
		for (int i = 0; i < N; i++) begin
			if (!resetn_i) begin
				count_q[i] <= '0;
			end else if (accept) begin
				count_q[i] <= count_q[i] + perf_comm_pkg::counter_t'(record_i[i*W +: W]);
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wall_q <= '0;
		end else if (enable) begin
			wall_q <= wall_q + 1'b1;	// one per enabled cycle
		end
	end

	// registered readback, one cycle behind comm_i
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			rb_q <= '0;
		end else if (rb_addr <= perf_comm_pkg::RB_EVENT_LAST) begin
			if (rb_addr[0]) begin
				rb_q <= count_q[rb_addr[4:1]][63:32];	// odd address, high half
			end else begin
				rb_q <= count_q[rb_addr[4:1]][31:0];
			end
		end else if (rb_addr == perf_comm_pkg::RB_WALL_LO) begin
			rb_q <= wall_q[31:0];
		end else if (rb_addr == perf_comm_pkg::RB_WALL_HI) begin
			rb_q <= wall_q[63:32];
		end else if (rb_addr == perf_comm_pkg::RB_CACHE_ID) begin
			rb_q <= `PERF_CACHE_ID;
		end else begin
			rb_q <= '0;	// unmapped
		end
	end

	assign ack_o = ack_q;
	assign comm_o = rb_q;

endmodule

`default_nettype wire

/* source/cache_perf_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "perf_monitor_cfg.svh"

module cache_perf_monitor (
	input  wire                           clock_i,
	input  wire                           resetn_i,
	input  wire                           hit_i,
	input  wire                           miss_i,
	input  wire                           writeback_i,
	input  wire                           expired_i,
	input  wire                           expired_multi_i,
	input  wire                           defaulted_i,
	input  wire                           rand_evict_i,
	input  wire                           swap_i,
	input  wire perf_comm_pkg::comm_word_t comm_i,
	output perf_comm_pkg::comm_word_t      comm_o,
	output logic                          stall_o
);

	cache_event_pkg::event_vec_t events;
	cache_event_pkg::delta_record_t smp_record;
	cache_event_pkg::delta_record_t fifo_record;
	logic smp_req;
	logic smp_ack;
	logic fifo_req;
	logic fifo_ack;

	always_comb begin
		events = '0;	// zero_lease and default_miss come from the sampler
		events[cache_event_pkg::ev_hit] = hit_i;
		events[cache_event_pkg::ev_miss] = miss_i;
		events[cache_event_pkg::ev_writeback] = writeback_i;
		events[cache_event_pkg::ev_expired] = expired_i;
		events[cache_event_pkg::ev_expired_multi] = expired_multi_i;
		events[cache_event_pkg::ev_defaulted] = defaulted_i;
		events[cache_event_pkg::ev_rand_evict] = rand_evict_i;
	end

	event_delta_sampler event_delta_sampler_i (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.comm_i   (comm_i),
		.events_i (events),
		.swap_i   (swap_i),
		.ack_i    (smp_ack),
		.req_o    (smp_req),
		.record_o (smp_record),
		.stall_o  (stall_o)
	);

	delta_record_fifo #(
		.DEPTH (`PERF_FIFO_DEPTH)
	) delta_record_fifo_i (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.req_i    (smp_req),
		.record_i (smp_record),
		.ack_i    (fifo_ack),
		.ack_o    (smp_ack),
		.req_o    (fifo_req),
		.record_o (fifo_record)
	);

	perf_counter_bank perf_counter_bank_i (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.comm_i   (comm_i),
		.req_i    (fifo_req),
		.record_i (fifo_record),
		.ack_o    (fifo_ack),
		.comm_o   (comm_o)
	);

endmodule

`default_nettype wire

/* verif/tb_cache_perf_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "perf_monitor_cfg.svh"

module tb_cache_perf_monitor;

	localparam int RESET_CYCLES = 5;
	localparam int DRAIN_CYCLES = 100;	// counters settle within this bound
	localparam int BURST_CYCLES = 3000;
	localparam int OFF_CYCLES = 400;
	localparam int SAT_CYCLES = 400;
	localparam int READ_CYCLES = 2 * (20 + 18 + 18 + 32 + 18);
	localparam int STIM_CYCLES = RESET_CYCLES + BURST_CYCLES + OFF_CYCLES + SAT_CYCLES +
		3 * DRAIN_CYCLES + READ_CYCLES + 16;

	logic clock_i;
	logic resetn_i;
	logic hit_i;
	logic miss_i;
	logic writeback_i;
	logic expired_i;
	logic expired_multi_i;
	logic defaulted_i;
	logic rand_evict_i;
	logic swap_i;
	logic [31:0] comm_i;
	logic [31:0] comm_o;
	logic stall_o;

	// reference model state
	logic [63:0] model_cnt [9];
	logic [63:0] model_wall;
	logic [8:0] model_cond;
	logic model_swap_prev;
	logic [31:0] rb_expected;
	logic rb_pending;

	cache_perf_monitor cache_perf_monitor_i (
		.clock_i         (clock_i),
		.resetn_i        (resetn_i),
		.hit_i           (hit_i),
		.miss_i          (miss_i),
		.writeback_i     (writeback_i),
		.expired_i       (expired_i),
		.expired_multi_i (expired_multi_i),
		.defaulted_i     (defaulted_i),
		.rand_evict_i    (rand_evict_i),
		.swap_i          (swap_i),
		.comm_i          (comm_i),
		.comm_o          (comm_o),
		.stall_o         (stall_o)
	);

	initial begin
		clock_i = 1'b0;
		forever #2 clock_i = ~clock_i;	// 4 ns period
	end

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
		abort_run();
	endtask

	function automatic logic [31:0] comm_word(input logic enable, input logic [4:0] addr);
		logic [31:0] word;
		word = '0;
		word[`PERF_ENABLE_BIT] = enable;
		word[4:0] = addr;
		return word;
	endfunction

	// readback value that the model predicts for an address
	function automatic logic [31:0] model_half(input logic [4:0] addr);
		logic [63:0] value;
		logic [31:0] result;
		int idx;
		idx = int'(addr) / 2;
		result = '0;
		if (addr <= 5'd17) begin
			value = model_cnt[idx];
			result = addr[0] ? value[63:32] : value[31:0];
		end else if (addr == 5'd18) begin
			result = model_wall[31:0];
		end else if (addr == 5'd19) begin
			result = model_wall[63:32];
		end else if (addr == 5'd30) begin
			result = `PERF_CACHE_ID;
		end
		return result;
	endfunction

	function automatic logic [4:0] random_upper_addr();
		return 5'(18 + ($urandom % 14));	// wall time, cache id and unmapped
	endfunction

	// model runs mid-cycle, where inputs and stall_o are settled
	always @(negedge clock_i) begin
		if (!resetn_i) begin
			for (int i = 0; i < 9; i++) begin
				model_cnt[i] = '0;
			end
			model_wall = '0;
			model_swap_prev = 1'b0;
			rb_pending = 1'b0;
		end else begin
			if (rb_pending) begin
				assert (comm_o == rb_expected)
					else report_mismatch("comm_o", rb_expected, comm_o);
			end
			rb_pending = (comm_i[4:0] >= 5'd18);	// event halves lag, read after drain
			rb_expected = model_half(comm_i[4:0]);
			model_cond = {miss_i & defaulted_i, model_swap_prev & ~swap_i, rand_evict_i,
				defaulted_i, expired_multi_i, expired_i, writeback_i, miss_i, hit_i};
			if (comm_i[`PERF_ENABLE_BIT]) begin
				if (!stall_o) begin
					for (int i = 0; i < 9; i++) begin
						if (model_cond[i]) begin
							model_cnt[i] = model_cnt[i] + 64'd1;
						end
					end
				end
				model_swap_prev = swap_i;
				model_wall = model_wall + 64'd1;
			end
		end
	end

	stall_low_after_reset: assert property (@(posedge clock_i) !resetn_i |=> !stall_o)
		else report_mismatch("stall_o", 32'd0, {31'd0, $sampled(stall_o)});

	comm_low_after_reset: assert property (@(posedge clock_i) !resetn_i |=> comm_o == 32'd0)
		else report_mismatch("comm_o", 32'd0, $sampled(comm_o));

	cache_id_readback: assert property (@(posedge clock_i) disable iff (!resetn_i)
		comm_i[4:0] == 5'd30 |=> comm_o == `PERF_CACHE_ID)
		else report_mismatch("comm_o", `PERF_CACHE_ID, $sampled(comm_o));

	task automatic drive_strobes(input logic [6:0] strobes, input logic swap);
		hit_i <= strobes[0];
		miss_i <= strobes[1];
		writeback_i <= strobes[2];
		expired_i <= strobes[3];
		expired_multi_i <= strobes[4];
		defaulted_i <= strobes[5];
		rand_evict_i <= strobes[6];
		swap_i <= swap;
	endtask

	// comm_o follows comm_i one cycle later
	task automatic read_check(input logic [4:0] addr);
		logic [31:0] expected;
		@(posedge clock_i);
		comm_i <= comm_word(comm_i[`PERF_ENABLE_BIT], addr);
		@(posedge clock_i);
		@(negedge clock_i);
		expected = model_half(addr);
		if (addr != 5'd18 && addr != 5'd19) begin	// wall time checked every cycle
			assert (comm_o == expected)
				else report_mismatch($sformatf("comm_o[%0d]", addr), expected, comm_o);
		end
	endtask

	task automatic read_range(input int lo, input int hi);
		for (int a = lo; a <= hi; a++) begin
			read_check(5'(a));
		end
	endtask

	// random strobes, held while stall_o is up
	task automatic run_random(input int cycles, input logic enable);
		logic [31:0] bits;
		logic [6:0] strobes;
		logic held;
		logic dense;
		held = 1'b0;
		dense = 1'b1;
		for (int c = 0; c < cycles; c++) begin
			@(posedge clock_i);
			if (c % 32 == 0) begin
				dense = ($urandom % 4) != 0;
			end
			if (!held) begin
				bits = $urandom;
				strobes = dense ? (bits[6:0] | bits[13:7]) : (bits[6:0] & bits[13:7] & bits[20:14]);
				drive_strobes(strobes, bits[21]);
			end
			comm_i <= comm_word(enable, random_upper_addr());
			@(negedge clock_i);
			held = stall_o;
		end
	endtask

	task automatic run_saturation(input int cycles);
		for (int c = 0; c < cycles; c++) begin
			@(posedge clock_i);
			drive_strobes(7'h7f, c[0]);	// swap toggles, zero lease every other cycle
			comm_i <= comm_word(1'b1, random_upper_addr());
		end
	endtask

	task automatic drain();
		@(posedge clock_i);
		drive_strobes(7'd0, 1'b0);
		comm_i <= comm_word(comm_i[`PERF_ENABLE_BIT], 5'd18);
		repeat (DRAIN_CYCLES) @(posedge clock_i);
	endtask

	initial begin
		#(4 * (STIM_CYCLES + 1000));
		$display("watchdog expired before the tests finished");
		abort_run();
	end

	initial begin
		void'($urandom(32'he011_fd4c));
		resetn_i = 1'b0;
		hit_i = 1'b0;
		miss_i = 1'b0;
		writeback_i = 1'b0;
		expired_i = 1'b0;
		expired_multi_i = 1'b0;
		defaulted_i = 1'b0;
		rand_evict_i = 1'b0;
		swap_i = 1'b0;
		comm_i = '0;
		repeat (RESET_CYCLES) @(posedge clock_i);
		resetn_i <= 1'b1;
		@(negedge clock_i);
		assert (!stall_o) else report_mismatch("stall_o", 32'd0, {31'd0, stall_o});
		assert (comm_o == 32'd0) else report_mismatch("comm_o", 32'd0, comm_o);
		read_range(0, 19);

		run_random(BURST_CYCLES, 1'b1);
		drain();
		read_range(0, 17);

		// counting off, counters and wall time hold
		run_random(OFF_CYCLES, 1'b0);
		drain();
		read_range(0, 17);

		@(posedge clock_i);
		comm_i <= comm_word(1'b1, 5'd18);
		read_range(0, 31);

		run_saturation(SAT_CYCLES);
		drain();
		read_range(0, 17);

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
source/cache_event_pkg.sv
source/perf_comm_pkg.sv
source/event_delta_sampler.sv
source/delta_record_fifo.sv
source/perf_counter_bank.sv
source/cache_perf_monitor.sv
verif/tb_cache_perf_monitor.sv

/* Makefile */
BIN := obj_dir/Vtb_cache_perf_monitor
SRCS := $(filter-out +%,$(shell cat sim.f)) include/perf_monitor_cfg.svh

.PHONY: run clean

run: $(BIN)
	./$(BIN) > sim.log 2>&1; cat sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

$(BIN): $(SRCS) sim.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_cache_perf_monitor -f sim.f

clean:
	rm -rf obj_dir sim.log
